//--- hdl/bus_defines.svh
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// bus geometry
`define BUS_ADDR_W 32
`define BUS_DATA_W 64
`define BUS_STRB_W 8

// top nibble A selects the mmio port
`define MMIO_BASE  32'hA000_0000
`define MMIO_MASK  32'hF000_0000

`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

//--- hdl/axi_pkg.sv
`default_nettype none
`include "bus_defines.svh"

package axi_pkg;

  // one bus address
  typedef logic [`BUS_ADDR_W-1:0] addr_t;

  // one 64-bit beat
  typedef logic [`BUS_DATA_W-1:0] data_t;

  typedef logic [`BUS_STRB_W-1:0] strb_t; // byte enables per beat

  // okay / slverr etc
  typedef logic [1:0] resp_t;

endpackage

`default_nettype wire

//--- hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // access width of a load or store
  typedef enum logic [1:0] {
    BYTE  = 2'd0,
    HALF  = 2'd1,
    WORD  = 2'd2,
    DWORD = 2'd3
  } size_e;

  typedef logic [31:0] instr_t; // one rv instruction

endpackage

`default_nettype wire

//--- hdl/axil_if.sv
`timescale 1ns/1ns
`default_nettype none

interface axil_if (
  input logic clk,
  input logic reset_i
);

  logic           aw_valid;
  logic           aw_ready;
  axi_pkg::addr_t aw_addr;

  logic           w_valid;
  logic           w_ready;
  axi_pkg::data_t w_data;
  axi_pkg::strb_t w_strb;

  logic           b_valid;
  logic           b_ready;
  axi_pkg::resp_t b_resp;

  logic           ar_valid;
  logic           ar_ready;
  axi_pkg::addr_t ar_addr;

  logic           r_valid;
  logic           r_ready;
  axi_pkg::data_t r_data;
  axi_pkg::resp_t r_resp;

  modport master (
    input  clk, reset_i,
    output aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
    output ar_valid, ar_addr, r_ready,
    input  aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
  );

  modport slave (
    input  clk, reset_i,
    input  aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
    input  ar_valid, ar_addr, r_ready,
    output aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
  );

endinterface

`default_nettype wire

//--- hdl/fetch_port.sv
`timescale 1ns/1ns
`default_nettype none
`include "bus_defines.svh"

module fetch_port (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            fetch_valid_i,
  input  axi_pkg::addr_t  fetch_addr_i,
  output logic            fetch_ready_o,
  output logic            fetch_rvalid_o,
  output lsu_pkg::instr_t fetch_instr_o,
  output logic            fetch_err_o,
  axil_if.master          bus_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR, // ar out, waiting for ar_ready
    S_DATA  // waiting for the beat
  } state_e;

  state_e         state_q;
  axi_pkg::addr_t addr_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q        <= S_IDLE;
      fetch_rvalid_o <= 1'b0;
    end else begin
      fetch_rvalid_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (fetch_valid_i) begin
            state_q <= S_ADDR;
          end
        end
        S_ADDR: begin
          if (bus_o.ar_ready) begin
            state_q <= S_DATA;
          end
        end
        S_DATA: begin
          if (bus_o.r_valid) begin
            state_q        <= S_IDLE;
            fetch_rvalid_o <= 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid_i && fetch_ready_o) begin
      addr_q <= fetch_addr_i;
    end
    if (state_q == S_DATA && bus_o.r_valid) begin
      // bit 2 picks the half of the beat
      fetch_instr_o <= addr_q[2] ? bus_o.r_data[63:32] : bus_o.r_data[31:0];
      fetch_err_o   <= (bus_o.r_resp != `AXI_RESP_OKAY);
    end
  end

  assign fetch_ready_o = (state_q == S_IDLE);

  assign bus_o.ar_valid = (state_q == S_ADDR);
  assign bus_o.ar_addr  = {addr_q[`BUS_ADDR_W-1:3], 3'b000}; // beat aligned
  assign bus_o.r_ready  = (state_q == S_DATA);

  // read-only agent, write side parked
  assign bus_o.aw_valid = 1'b0;
  assign bus_o.aw_addr  = '0;
  assign bus_o.w_valid  = 1'b0;
  assign bus_o.w_data   = '0;
  assign bus_o.w_strb   = '0;
  assign bus_o.b_ready  = 1'b0;

  a_ar_stable: assert property (@(posedge clk) disable iff (reset_i)
    bus_o.ar_valid && !bus_o.ar_ready |=> bus_o.ar_valid && $stable(bus_o.ar_addr));

endmodule

`default_nettype wire

//--- hdl/ls_port.sv
`timescale 1ns/1ns
`default_nettype none
`include "bus_defines.svh"

module ls_port (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            ls_valid_i,
  input  logic            ls_we_i,
  input  axi_pkg::addr_t  ls_addr_i,
  input  lsu_pkg::size_e  ls_size_i,
  input  logic            ls_unsigned_i,
  input  axi_pkg::data_t  ls_wdata_i,
  output logic            ls_ready_o,
  output logic            ls_done_o,
  output axi_pkg::data_t  ls_rdata_o,
  output logic            ls_err_o,
  axil_if.master          bus_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_RD_ADDR,
    S_RD_DATA,
    S_WRITE    // aw/w outstanding, then b
  } state_e;

  state_e         state_q;
  logic           aw_pend_q;
  logic           w_pend_q;
  axi_pkg::addr_t addr_q;
  lsu_pkg::size_e size_q;
  logic           unsigned_q;
  axi_pkg::data_t wdata_q;
  axi_pkg::strb_t strb_q;

  logic           accept;
  logic           misalign;
  axi_pkg::strb_t strb_base;
  axi_pkg::data_t rshift;
  axi_pkg::data_t load_fmt;
  logic           r_fire;
  logic           b_fire;

  assign accept = ls_valid_i && ls_ready_o;
  assign r_fire = (state_q == S_RD_DATA) && bus_o.r_valid;
  assign b_fire = bus_o.b_valid && bus_o.b_ready;

  // alignment and lane mask from size
  always_comb begin
    case (ls_size_i)
      lsu_pkg::BYTE: begin
        misalign  = 1'b0;
        strb_base = 8'h01;
      end
      lsu_pkg::HALF: begin
        misalign  = ls_addr_i[0];
        strb_base = 8'h03;
      end
      lsu_pkg::WORD: begin
        misalign  = |ls_addr_i[1:0];
        strb_base = 8'h0f;
      end
      default: begin
        misalign  = |ls_addr_i[2:0];
        strb_base = 8'hff;
      end
    endcase
  end

  // bring the addressed bytes down to lane 0, then extend
  assign rshift = bus_o.r_data >> {addr_q[2:0], 3'b000};

  always_comb begin
    case (size_q)
      lsu_pkg::BYTE:
        load_fmt = {{56{rshift[7] & ~unsigned_q}}, rshift[7:0]};
      lsu_pkg::HALF:
        load_fmt = {{48{rshift[15] & ~unsigned_q}}, rshift[15:0]};
      lsu_pkg::WORD:
        load_fmt = {{32{rshift[31] & ~unsigned_q}}, rshift[31:0]};
      default:
        load_fmt = rshift;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q   <= S_IDLE;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
      ls_done_o <= 1'b0;
    end else begin
      ls_done_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (accept && misalign) begin
            ls_done_o <= 1'b1; // rejected, nothing on the bus
          end else if (accept && ls_we_i) begin
            state_q   <= S_WRITE;
            aw_pend_q <= 1'b1;
            w_pend_q  <= 1'b1;
          end else if (accept) begin
            state_q <= S_RD_ADDR;
          end
        end
        S_RD_ADDR: begin
          if (bus_o.ar_ready) begin
            state_q <= S_RD_DATA;
          end
        end
        S_RD_DATA: begin
          if (bus_o.r_valid) begin
            state_q   <= S_IDLE;
            ls_done_o <= 1'b1;
          end
        end
        default: begin
          // aw and w complete on their own
          if (bus_o.aw_ready) begin
            aw_pend_q <= 1'b0;
          end
          if (bus_o.w_ready) begin
            w_pend_q <= 1'b0;
          end
          if (b_fire) begin
            state_q   <= S_IDLE;
            ls_done_o <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q     <= ls_addr_i;
      size_q     <= ls_size_i;
      unsigned_q <= ls_unsigned_i;
      wdata_q    <= ls_wdata_i << {ls_addr_i[2:0], 3'b000};
      strb_q     <= strb_base << ls_addr_i[2:0];
    end
    if (accept && misalign) begin
      ls_err_o <= 1'b1;
    end else if (r_fire) begin
      ls_rdata_o <= load_fmt;
      ls_err_o   <= (bus_o.r_resp != `AXI_RESP_OKAY);
    end else if (b_fire) begin
      ls_err_o <= (bus_o.b_resp != `AXI_RESP_OKAY);
    end
  end

  assign ls_ready_o = (state_q == S_IDLE);

  assign bus_o.ar_valid = (state_q == S_RD_ADDR);
  assign bus_o.ar_addr  = {addr_q[`BUS_ADDR_W-1:3], 3'b000};
  assign bus_o.r_ready  = (state_q == S_RD_DATA);
  assign bus_o.aw_valid = aw_pend_q;
  assign bus_o.aw_addr  = {addr_q[`BUS_ADDR_W-1:3], 3'b000};
  assign bus_o.w_valid  = w_pend_q;
  assign bus_o.w_data   = wdata_q;
  assign bus_o.w_strb   = strb_q;
  assign bus_o.b_ready  = (state_q == S_WRITE) && !aw_pend_q && !w_pend_q;

  a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (reset_i)
    !(bus_o.ar_valid && bus_o.aw_valid));

  a_strb_nonzero: assert property (@(posedge clk) disable iff (reset_i)
    bus_o.w_valid |-> bus_o.w_strb != '0);

endmodule

`default_nettype wire

//--- hdl/axil_crossbar.sv
`timescale 1ns/1ns
`default_nettype none
`include "bus_defines.svh"

module axil_crossbar (
  input logic    clk,
  input logic    reset_i,
  axil_if.slave  fetch_s,
  axil_if.slave  ls_s,
  axil_if.master mem_m,
  axil_if.master mmio_m
);

  function automatic logic is_mmio(input axi_pkg::addr_t addr);
    return (addr & `MMIO_MASK) == `MMIO_BASE;
  endfunction

  logic           rd_lock_q;   // grant frozen from first ar_valid to r
  logic           rd_open_q;   // ar done, r pending
  logic           rd_own_ls_q;
  logic           rd_mmio_q;
  logic           wr_busy_q;
  logic           wr_mmio_q;

  logic           own_ls;
  logic           ar_valid;
  axi_pkg::addr_t ar_addr;
  logic           ar_mmio;
  logic           ar_ready;
  logic           ar_fire;
  logic           r_valid;
  logic           r_ready;
  logic           r_fire;
  axi_pkg::data_t r_data;
  axi_pkg::resp_t r_resp;
  logic           wr_mmio;
  logic           b_fire;

  // read arbitration, ls wins while unlocked
  assign own_ls   = rd_lock_q ? rd_own_ls_q : ls_s.ar_valid;
  assign ar_valid = own_ls ? ls_s.ar_valid : fetch_s.ar_valid;
  assign ar_addr  = own_ls ? ls_s.ar_addr : fetch_s.ar_addr;
  assign ar_mmio  = is_mmio(ar_addr);
  assign ar_ready = ar_mmio ? mmio_m.ar_ready : mem_m.ar_ready;
  assign ar_fire  = ar_valid && ar_ready;

  assign mem_m.ar_valid   = ar_valid && !ar_mmio;
  assign mmio_m.ar_valid  = ar_valid && ar_mmio;
  assign mem_m.ar_addr    = ar_addr;
  assign mmio_m.ar_addr   = ar_addr;
  assign fetch_s.ar_ready = !own_ls && ar_ready;
  assign ls_s.ar_ready    = own_ls && ar_ready;

  // r back to whoever owns the open read
  assign r_valid = rd_open_q && (rd_mmio_q ? mmio_m.r_valid : mem_m.r_valid);
  assign r_data  = rd_mmio_q ? mmio_m.r_data : mem_m.r_data;
  assign r_resp  = rd_mmio_q ? mmio_m.r_resp : mem_m.r_resp;
  assign r_ready = rd_own_ls_q ? ls_s.r_ready : fetch_s.r_ready;
  assign r_fire  = r_valid && r_ready;

  assign mem_m.r_ready   = rd_open_q && !rd_mmio_q && r_ready;
  assign mmio_m.r_ready  = rd_open_q && rd_mmio_q && r_ready;
  assign fetch_s.r_valid = r_valid && !rd_own_ls_q;
  assign ls_s.r_valid    = r_valid && rd_own_ls_q;
  assign fetch_s.r_data  = r_data;
  assign ls_s.r_data     = r_data;
  assign fetch_s.r_resp  = r_resp;
  assign ls_s.r_resp     = r_resp;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rd_lock_q   <= 1'b0;
      rd_open_q   <= 1'b0;
      rd_own_ls_q <= 1'b0;
      rd_mmio_q   <= 1'b0;
    end else begin
      if (!rd_lock_q) begin
        rd_own_ls_q <= own_ls;
      end
      if (ar_fire) begin
        rd_mmio_q <= ar_mmio;
      end
      if (r_fire) begin
        rd_lock_q <= 1'b0;
        rd_open_q <= 1'b0;
      end else begin
        if (ar_valid) begin
          rd_lock_q <= 1'b1;
        end
        if (ar_fire) begin
          rd_open_q <= 1'b1;
        end
      end
    end
  end

  // writes only from ls, route follows aw until b
  assign wr_mmio = wr_busy_q ? wr_mmio_q : is_mmio(ls_s.aw_addr);
  assign b_fire  = ls_s.b_valid && ls_s.b_ready;

  assign mem_m.aw_valid  = ls_s.aw_valid && !wr_mmio;
  assign mmio_m.aw_valid = ls_s.aw_valid && wr_mmio;
  assign mem_m.aw_addr   = ls_s.aw_addr;
  assign mmio_m.aw_addr  = ls_s.aw_addr;
  assign ls_s.aw_ready   = wr_mmio ? mmio_m.aw_ready : mem_m.aw_ready;

  assign mem_m.w_valid   = ls_s.w_valid && !wr_mmio;
  assign mmio_m.w_valid  = ls_s.w_valid && wr_mmio;
  assign mem_m.w_data    = ls_s.w_data;
  assign mmio_m.w_data   = ls_s.w_data;
  assign mem_m.w_strb    = ls_s.w_strb;
  assign mmio_m.w_strb   = ls_s.w_strb;
  assign ls_s.w_ready    = wr_mmio ? mmio_m.w_ready : mem_m.w_ready;

  assign mem_m.b_ready   = ls_s.b_ready && !wr_mmio;
  assign mmio_m.b_ready  = ls_s.b_ready && wr_mmio;
  assign ls_s.b_valid    = wr_mmio ? mmio_m.b_valid : mem_m.b_valid;
  assign ls_s.b_resp     = wr_mmio ? mmio_m.b_resp : mem_m.b_resp;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_busy_q <= 1'b0;
      wr_mmio_q <= 1'b0;
    end else if (b_fire) begin
      wr_busy_q <= 1'b0;
    end else if (ls_s.aw_valid && !wr_busy_q) begin
      wr_busy_q <= 1'b1;
      wr_mmio_q <= is_mmio(ls_s.aw_addr);
    end
  end

  // fetch has no write side
  assign fetch_s.aw_ready = 1'b0;
  assign fetch_s.w_ready  = 1'b0;
  assign fetch_s.b_valid  = 1'b0;
  assign fetch_s.b_resp   = `AXI_RESP_OKAY;

  // only one master may be waiting for read data
  a_one_owner: assert property (@(posedge clk) disable iff (reset_i)
    $onehot0({fetch_s.r_ready, ls_s.r_ready}));

  // relies on both ports holding ar low until their r
  a_no_second_ar: assert property (@(posedge clk) disable iff (reset_i)
    rd_open_q |-> !(mem_m.ar_valid || mmio_m.ar_valid));

endmodule

`default_nettype wire

//--- hdl/mem_bus_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_bus_top (
  input  logic            clk,
  input  logic            reset_i,

  input  logic            fetch_valid_i,
  input  axi_pkg::addr_t  fetch_addr_i,
  output logic            fetch_ready_o,
  output logic            fetch_rvalid_o,
  output lsu_pkg::instr_t fetch_instr_o,
  output logic            fetch_err_o,

  input  logic            ls_valid_i,
  input  logic            ls_we_i,
  input  axi_pkg::addr_t  ls_addr_i,
  input  lsu_pkg::size_e  ls_size_i,
  input  logic            ls_unsigned_i,
  input  axi_pkg::data_t  ls_wdata_i,
  output logic            ls_ready_o,
  output logic            ls_done_o,
  output axi_pkg::data_t  ls_rdata_o,
  output logic            ls_err_o,

  // main memory
  output logic            mem_aw_valid_o,
  input  logic            mem_aw_ready_i,
  output axi_pkg::addr_t  mem_aw_addr_o,
  output logic            mem_w_valid_o,
  input  logic            mem_w_ready_i,
  output axi_pkg::data_t  mem_w_data_o,
  output axi_pkg::strb_t  mem_w_strb_o,
  input  logic            mem_b_valid_i,
  output logic            mem_b_ready_o,
  input  axi_pkg::resp_t  mem_b_resp_i,
  output logic            mem_ar_valid_o,
  input  logic            mem_ar_ready_i,
  output axi_pkg::addr_t  mem_ar_addr_o,
  input  logic            mem_r_valid_i,
  output logic            mem_r_ready_o,
  input  axi_pkg::data_t  mem_r_data_i,
  input  axi_pkg::resp_t  mem_r_resp_i,

  // mmio
  output logic            mmio_aw_valid_o,
  input  logic            mmio_aw_ready_i,
  output axi_pkg::addr_t  mmio_aw_addr_o,
  output logic            mmio_w_valid_o,
  input  logic            mmio_w_ready_i,
  output axi_pkg::data_t  mmio_w_data_o,
  output axi_pkg::strb_t  mmio_w_strb_o,
  input  logic            mmio_b_valid_i,
  output logic            mmio_b_ready_o,
  input  axi_pkg::resp_t  mmio_b_resp_i,
  output logic            mmio_ar_valid_o,
  input  logic            mmio_ar_ready_i,
  output axi_pkg::addr_t  mmio_ar_addr_o,
  input  logic            mmio_r_valid_i,
  output logic            mmio_r_ready_o,
  input  axi_pkg::data_t  mmio_r_data_i,
  input  axi_pkg::resp_t  mmio_r_resp_i
);

  axil_if fetch_bus (.clk(clk), .reset_i(reset_i));
  axil_if ls_bus    (.clk(clk), .reset_i(reset_i));
  axil_if mem_bus   (.clk(clk), .reset_i(reset_i));
  axil_if mmio_bus  (.clk(clk), .reset_i(reset_i));

  fetch_port fetch_port_u (
    .clk            (clk),
    .reset_i        (reset_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_rvalid_o (fetch_rvalid_o),
    .fetch_instr_o  (fetch_instr_o),
    .fetch_err_o    (fetch_err_o),
    .bus_o          (fetch_bus.master)
  );

  ls_port ls_port_u (
    .clk           (clk),
    .reset_i       (reset_i),
    .ls_valid_i    (ls_valid_i),
    .ls_we_i       (ls_we_i),
    .ls_addr_i     (ls_addr_i),
    .ls_size_i     (ls_size_i),
    .ls_unsigned_i (ls_unsigned_i),
    .ls_wdata_i    (ls_wdata_i),
    .ls_ready_o    (ls_ready_o),
    .ls_done_o     (ls_done_o),
    .ls_rdata_o    (ls_rdata_o),
    .ls_err_o      (ls_err_o),
    .bus_o         (ls_bus.master)
  );

  axil_crossbar axil_crossbar_u (
    .clk     (clk),
    .reset_i (reset_i),
    .fetch_s (fetch_bus.slave),
    .ls_s    (ls_bus.slave),
    .mem_m   (mem_bus.master),
    .mmio_m  (mmio_bus.master)
  );

  assign mem_aw_valid_o   = mem_bus.aw_valid;
  assign mem_bus.aw_ready = mem_aw_ready_i;
  assign mem_aw_addr_o    = mem_bus.aw_addr;
  assign mem_w_valid_o    = mem_bus.w_valid;
  assign mem_bus.w_ready  = mem_w_ready_i;
  assign mem_w_data_o     = mem_bus.w_data;
  assign mem_w_strb_o     = mem_bus.w_strb;
  assign mem_bus.b_valid  = mem_b_valid_i;
  assign mem_b_ready_o    = mem_bus.b_ready;
  assign mem_bus.b_resp   = mem_b_resp_i;
  assign mem_ar_valid_o   = mem_bus.ar_valid;
  assign mem_bus.ar_ready = mem_ar_ready_i;
  assign mem_ar_addr_o    = mem_bus.ar_addr;
  assign mem_bus.r_valid  = mem_r_valid_i;
  assign mem_r_ready_o    = mem_bus.r_ready;
  assign mem_bus.r_data   = mem_r_data_i;
  assign mem_bus.r_resp   = mem_r_resp_i;

  assign mmio_aw_valid_o   = mmio_bus.aw_valid;
  assign mmio_bus.aw_ready = mmio_aw_ready_i;
  assign mmio_aw_addr_o    = mmio_bus.aw_addr;
  assign mmio_w_valid_o    = mmio_bus.w_valid;
  assign mmio_bus.w_ready  = mmio_w_ready_i;
  assign mmio_w_data_o     = mmio_bus.w_data;
  assign mmio_w_strb_o     = mmio_bus.w_strb;
  assign mmio_bus.b_valid  = mmio_b_valid_i;
  assign mmio_b_ready_o    = mmio_bus.b_ready;
  assign mmio_bus.b_resp   = mmio_b_resp_i;
  assign mmio_ar_valid_o   = mmio_bus.ar_valid;
  assign mmio_bus.ar_ready = mmio_ar_ready_i;
  assign mmio_ar_addr_o    = mmio_bus.ar_addr;
  assign mmio_bus.r_valid  = mmio_r_valid_i;
  assign mmio_r_ready_o    = mmio_bus.r_ready;
  assign mmio_bus.r_data   = mmio_r_data_i;
  assign mmio_bus.r_resp   = mmio_r_resp_i;

endmodule

`default_nettype wire

//--- tb/axil_slave_model.sv
`timescale 1ns/1ns
`default_nettype none
`include "bus_defines.svh"

module axil_slave_model #(
  parameter axi_pkg::addr_t BASE   = 32'h0000_0000,
  parameter axi_pkg::addr_t ERR_LO = 32'h0000_0001, // lo > hi means no error window
  parameter axi_pkg::addr_t ERR_HI = 32'h0000_0000
) (
  input  logic           clk,
  input  logic           reset_i,
  input  logic           aw_valid_i,
  output logic           aw_ready_o,
  input  axi_pkg::addr_t aw_addr_i,
  input  logic           w_valid_i,
  output logic           w_ready_o,
  input  axi_pkg::data_t w_data_i,
  input  axi_pkg::strb_t w_strb_i,
  output logic           b_valid_o,
  input  logic           b_ready_i,
  output axi_pkg::resp_t b_resp_o,
  input  logic           ar_valid_i,
  output logic           ar_ready_o,
  input  axi_pkg::addr_t ar_addr_i,
  output logic           r_valid_o,
  input  logic           r_ready_i,
  output axi_pkg::data_t r_data_o,
  output axi_pkg::resp_t r_resp_o
);

  axi_pkg::data_t mem [0:511]; // 4 KiB, aliased above that
  integer         seed = 32'hb7e0;
  logic [31:0]    rnd;
  logic           rd_pend;
  axi_pkg::addr_t rd_addr;
  logic           got_aw;
  logic           got_w;
  axi_pkg::addr_t wr_addr;
  axi_pkg::data_t wr_data;
  axi_pkg::strb_t wr_strb;
  axi_pkg::addr_t fill_addr;

  function automatic logic in_err(input axi_pkg::addr_t a);
    return (a >= ERR_LO) && (a <= ERR_HI);
  endfunction

  initial begin
    for (int i = 0; i < 512; i++) begin
      fill_addr = BASE | axi_pkg::addr_t'(i << 3);
      mem[i]    = {fill_addr ^ 32'h5a5a_0000, ~fill_addr};
    end
  end

  always @(posedge clk) begin
    rnd = $random(seed);
    if (reset_i) begin
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      b_valid_o  <= 1'b0;
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      rd_pend    <= 1'b0;
      got_aw     <= 1'b0;
      got_w      <= 1'b0;
    end else begin
      // read side, one at a time
      ar_ready_o <= !rd_pend && !(ar_valid_i && ar_ready_o) && (rnd[0] | rnd[1]);
      if (ar_valid_i && ar_ready_o) begin
        rd_pend <= 1'b1;
        rd_addr <= ar_addr_i;
      end
      if (rd_pend && !r_valid_o && rnd[2]) begin
        r_valid_o <= 1'b1;
        r_data_o  <= mem[rd_addr[11:3]];
        r_resp_o  <= in_err(rd_addr) ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
      end
      if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
        rd_pend   <= 1'b0;
      end
      // write side, aw and w may come in any order
      aw_ready_o <= !got_aw && !(aw_valid_i && aw_ready_o) && (rnd[3] | rnd[4]);
      w_ready_o  <= !got_w && !(w_valid_i && w_ready_o) && (rnd[5] | rnd[6]);
      if (aw_valid_i && aw_ready_o) begin
        got_aw  <= 1'b1;
        wr_addr <= aw_addr_i;
      end
      if (w_valid_i && w_ready_o) begin
        got_w   <= 1'b1;
        wr_data <= w_data_i;
        wr_strb <= w_strb_i;
      end
      if (got_aw && got_w && !b_valid_o && rnd[7]) begin
        b_valid_o <= 1'b1;
        b_resp_o  <= in_err(wr_addr) ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
        for (int b = 0; b < 8; b++) begin
          if (wr_strb[b] && !in_err(wr_addr)) begin
            mem[wr_addr[11:3]][b*8 +: 8] <= wr_data[b*8 +: 8];
          end
        end
      end
      if (b_valid_o && b_ready_i) begin
        b_valid_o <= 1'b0;
        got_aw    <= 1'b0;
        got_w     <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_mem_bus.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_bus;

  logic clk = 1'b0;
  logic reset_i;
  logic fetch_valid_i, fetch_ready_o, fetch_rvalid_o, fetch_err_o;
  axi_pkg::addr_t fetch_addr_i;
  lsu_pkg::instr_t fetch_instr_o;
  logic ls_valid_i, ls_we_i, ls_unsigned_i, ls_ready_o, ls_done_o, ls_err_o;
  axi_pkg::addr_t ls_addr_i;
  lsu_pkg::size_e ls_size_i;
  axi_pkg::data_t ls_wdata_i, ls_rdata_o;

  logic mem_aw_valid_o, mem_aw_ready_i, mem_w_valid_o, mem_w_ready_i, mem_b_valid_i;
  logic mem_b_ready_o, mem_ar_valid_o, mem_ar_ready_i, mem_r_valid_i, mem_r_ready_o;
  axi_pkg::addr_t mem_aw_addr_o, mem_ar_addr_o;
  axi_pkg::data_t mem_w_data_o, mem_r_data_i;
  axi_pkg::strb_t mem_w_strb_o;
  axi_pkg::resp_t mem_b_resp_i, mem_r_resp_i;
  logic mmio_aw_valid_o, mmio_aw_ready_i, mmio_w_valid_o, mmio_w_ready_i, mmio_b_valid_i;
  logic mmio_b_ready_o, mmio_ar_valid_o, mmio_ar_ready_i, mmio_r_valid_i, mmio_r_ready_o;
  axi_pkg::addr_t mmio_aw_addr_o, mmio_ar_addr_o;
  axi_pkg::data_t mmio_w_data_o, mmio_r_data_i;
  axi_pkg::strb_t mmio_w_strb_o;
  axi_pkg::resp_t mmio_b_resp_i, mmio_r_resp_i;

  integer seed = 32'hb7e0;
  logic   watch_bus = 1'b0;
  logic   bus_seen = 1'b0;
  int     fetch_pulses = 0;
  int     ls_pulses = 0;

  mem_bus_top dut0 (.*);

  // mem errors in 0x2000..0x2fff, mmio has none
  axil_slave_model #(.BASE(32'h0000_0000), .ERR_LO(32'h0000_2000), .ERR_HI(32'h0000_2fff))
    mem_model (
      .clk(clk), .reset_i(reset_i),
      .aw_valid_i(mem_aw_valid_o), .aw_ready_o(mem_aw_ready_i), .aw_addr_i(mem_aw_addr_o),
      .w_valid_i(mem_w_valid_o), .w_ready_o(mem_w_ready_i), .w_data_i(mem_w_data_o),
      .w_strb_i(mem_w_strb_o), .b_valid_o(mem_b_valid_i), .b_ready_i(mem_b_ready_o),
      .b_resp_o(mem_b_resp_i), .ar_valid_i(mem_ar_valid_o), .ar_ready_o(mem_ar_ready_i),
      .ar_addr_i(mem_ar_addr_o), .r_valid_o(mem_r_valid_i), .r_ready_i(mem_r_ready_o),
      .r_data_o(mem_r_data_i), .r_resp_o(mem_r_resp_i));

  axil_slave_model #(.BASE(32'hA000_0000)) mmio_model (
    .clk(clk), .reset_i(reset_i),
    .aw_valid_i(mmio_aw_valid_o), .aw_ready_o(mmio_aw_ready_i), .aw_addr_i(mmio_aw_addr_o),
    .w_valid_i(mmio_w_valid_o), .w_ready_o(mmio_w_ready_i), .w_data_i(mmio_w_data_o),
    .w_strb_i(mmio_w_strb_o), .b_valid_o(mmio_b_valid_i), .b_ready_i(mmio_b_ready_o),
    .b_resp_o(mmio_b_resp_i), .ar_valid_i(mmio_ar_valid_o), .ar_ready_o(mmio_ar_ready_i),
    .ar_addr_i(mmio_ar_addr_o), .r_valid_o(mmio_r_valid_i), .r_ready_i(mmio_r_ready_o),
    .r_data_o(mmio_r_data_i), .r_resp_o(mmio_r_resp_i));

  always #2 clk = ~clk;

  // cleared while not watching
  always @(posedge clk) begin
    if (!watch_bus) begin
      bus_seen <= 1'b0;
    end else if (mem_ar_valid_o || mem_aw_valid_o || mem_w_valid_o ||
                 mmio_ar_valid_o || mmio_aw_valid_o || mmio_w_valid_o) begin
      bus_seen <= 1'b1;
    end
  end

  always @(posedge clk) begin
    if (fetch_rvalid_o) begin
      fetch_pulses <= fetch_pulses + 1;
    end
    if (ls_done_o) begin
      ls_pulses <= ls_pulses + 1;
    end
  end

  task automatic stop_fail(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "run stopped");
  endtask

  task automatic check_data(input string name, input axi_pkg::data_t exp,
                            input axi_pkg::data_t act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
      stop_fail("data mismatch");
    end
  endtask

  task automatic check_instr(input string name, input lsu_pkg::instr_t exp,
                             input lsu_pkg::instr_t act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
      stop_fail("instruction mismatch");
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
      stop_fail("error flag mismatch");
    end
  endtask

  // initial contents of both slave arrays
  function automatic axi_pkg::data_t fill_word(input axi_pkg::addr_t a);
    axi_pkg::addr_t w;
    w = {a[31:3], 3'b000};
    return {w ^ 32'h5a5a_0000, ~w};
  endfunction

  // bit 2 picks the upper or lower half of the beat
  function automatic lsu_pkg::instr_t fill_instr(input axi_pkg::addr_t a);
    axi_pkg::data_t w;
    w = fill_word(a);
    return a[2] ? w[63:32] : w[31:0];
  endfunction

  function automatic axi_pkg::data_t extend(input axi_pkg::data_t v,
                                            input lsu_pkg::size_e s, input logic uns);
    case (s)
      lsu_pkg::BYTE: return uns ? {56'd0, v[7:0]} : {{56{v[7]}}, v[7:0]};
      lsu_pkg::HALF: return uns ? {48'd0, v[15:0]} : {{48{v[15]}}, v[15:0]};
      lsu_pkg::WORD: return uns ? {32'd0, v[31:0]} : {{32{v[31]}}, v[31:0]};
      default:       return v;
    endcase
  endfunction

  // old beat with the stored bytes laid in at the offset
  function automatic axi_pkg::data_t merge(input axi_pkg::data_t old, input axi_pkg::data_t v,
                                           input lsu_pkg::size_e s, input int off);
    axi_pkg::data_t r;
    r = old;
    for (int b = 0; b < 8; b++) begin
      if (b >= off && b < off + (1 << int'(s))) begin
        r[b*8 +: 8] = v[(b-off)*8 +: 8];
      end
    end
    return r;
  endfunction

  task automatic do_fetch(input axi_pkg::addr_t a, output lsu_pkg::instr_t instr,
                          output logic err);
    int n;
    n = 0;
    if (!fetch_ready_o) stop_fail("fetch port not ready for a new request");
    fetch_valid_i = 1'b1;
    fetch_addr_i  = a;
    @(posedge clk);
    #1 fetch_valid_i = 1'b0;
    while (!fetch_rvalid_o) begin
      @(posedge clk);
      #1 n++;
      if (n > 200) stop_fail("no fetch response pulse");
    end
    instr = fetch_instr_o;
    err   = fetch_err_o;
  endtask

  task automatic do_ls(input logic we, input axi_pkg::addr_t a, input lsu_pkg::size_e s,
                       input logic uns, input axi_pkg::data_t wd,
                       output axi_pkg::data_t rd, output logic err);
    int n;
    n = 0;
    if (!ls_ready_o) stop_fail("load/store port not ready for a new request");
    ls_valid_i    = 1'b1;
    ls_we_i       = we;
    ls_addr_i     = a;
    ls_size_i     = s;
    ls_unsigned_i = uns;
    ls_wdata_i    = wd;
    @(posedge clk);
    #1 ls_valid_i = 1'b0;
    while (!ls_done_o) begin
      @(posedge clk);
      #1 n++;
      if (n > 200) stop_fail("no load/store done pulse");
    end
    rd  = ls_rdata_o;
    err = ls_err_o;
  endtask

  task automatic test_fetch();
    lsu_pkg::instr_t ins;
    logic e;
    axi_pkg::addr_t a;
    for (int i = 0; i < 4; i++) begin
      a = 32'h0000_0010 + axi_pkg::addr_t'(i * 4); // bit 2 alternates
      do_fetch(a, ins, e);
      check_instr("fetch_instr_o", fill_instr(a), ins);
      check_err("fetch_err_o", 1'b0, e);
    end
  endtask

  task automatic test_store_load();
    axi_pkg::data_t v, rd;
    axi_pkg::addr_t base, a;
    logic e;
    int off;
    for (int s = 0; s < 4; s++) begin
      base = 32'h0000_0200 + axi_pkg::addr_t'(s * 16);
      off  = 8 - (1 << s);
      a    = base + axi_pkg::addr_t'(off);
      v    = {$random(seed), $random(seed)};
      do_ls(1'b1, a, lsu_pkg::size_e'(s), 1'b0, v, rd, e);
      check_err("ls_err_o", 1'b0, e);
      do_ls(1'b0, a, lsu_pkg::size_e'(s), 1'b0, '0, rd, e);
      check_data("ls_rdata_o", extend(v, lsu_pkg::size_e'(s), 1'b0), rd);
      do_ls(1'b0, a, lsu_pkg::size_e'(s), 1'b1, '0, rd, e);
      check_data("ls_rdata_o", extend(v, lsu_pkg::size_e'(s), 1'b1), rd);
      do_ls(1'b0, base, lsu_pkg::DWORD, 1'b0, '0, rd, e);
      check_data("ls_rdata_o", merge(fill_word(base), v, lsu_pkg::size_e'(s), off), rd);
    end
  endtask

  task automatic test_mmio();
    axi_pkg::data_t rd;
    logic e;
    do_ls(1'b1, 32'hA000_0040, lsu_pkg::DWORD, 1'b0, 64'h0123_4567_89ab_cdef, rd, e);
    check_err("ls_err_o", 1'b0, e);
    do_ls(1'b0, 32'hA000_0040, lsu_pkg::DWORD, 1'b0, '0, rd, e);
    check_data("ls_rdata_o", 64'h0123_4567_89ab_cdef, rd);
    do_ls(1'b0, 32'h0000_0040, lsu_pkg::DWORD, 1'b0, '0, rd, e);
    check_data("ls_rdata_o", fill_word(32'h0000_0040), rd); // mem untouched
    do_ls(1'b0, 32'hA000_0080, lsu_pkg::DWORD, 1'b0, '0, rd, e);
    check_data("ls_rdata_o", fill_word(32'hA000_0080), rd);
  endtask

  task automatic test_errors();
    axi_pkg::data_t rd;
    lsu_pkg::instr_t ins;
    logic e;
    watch_bus = 1'b1;
    do_ls(1'b0, 32'h0000_0101, lsu_pkg::HALF, 1'b0, '0, rd, e);
    check_err("ls_err_o", 1'b1, e);
    do_ls(1'b1, 32'h0000_0102, lsu_pkg::WORD, 1'b0, '1, rd, e);
    check_err("ls_err_o", 1'b1, e);
    do_ls(1'b0, 32'h0000_0104, lsu_pkg::DWORD, 1'b0, '0, rd, e);
    check_err("ls_err_o", 1'b1, e);
    @(posedge clk);
    #1 watch_bus = 1'b0;
    check_err("bus_valid_seen", 1'b0, bus_seen);
    do_fetch(32'h0000_2004, ins, e);
    check_err("fetch_err_o", 1'b1, e);
    do_ls(1'b0, 32'h0000_2008, lsu_pkg::DWORD, 1'b0, '0, rd, e);
    check_err("ls_err_o", 1'b1, e);
    do_ls(1'b1, 32'h0000_2010, lsu_pkg::WORD, 1'b0, 64'h55, rd, e);
    check_err("ls_err_o", 1'b1, e);
  endtask

  task automatic test_concurrent();
    lsu_pkg::instr_t ins;
    axi_pkg::data_t rd;
    logic fe, le;
    int f0, l0;
    // one edge so the last done pulse is already counted
    @(posedge clk);
    #1;
    f0 = fetch_pulses;
    l0 = ls_pulses;
    fork
      do_fetch(32'h0000_0304, ins, fe);
      do_ls(1'b0, 32'h0000_0308, lsu_pkg::WORD, 1'b0, '0, rd, le);
    join
    check_instr("fetch_instr_o", fill_instr(32'h0000_0304), ins);
    check_data("ls_rdata_o", extend(fill_word(32'h0000_0308), lsu_pkg::WORD, 1'b0), rd);
    check_err("fetch_err_o", 1'b0, fe);
    check_err("ls_err_o", 1'b0, le);
    repeat (20) @(posedge clk);
    #1;
    if (fetch_pulses != f0 + 1 || ls_pulses != l0 + 1) begin
      stop_fail("fetch or load/store response did not pulse exactly once");
    end
  endtask

  initial begin
    #(40 * 200 * 4);
    stop_fail("watchdog expired, simulation hung");
  end

  initial begin
    reset_i       = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = '0;
    ls_valid_i    = 1'b0;
    ls_we_i       = 1'b0;
    ls_addr_i     = '0;
    ls_size_i     = lsu_pkg::BYTE;
    ls_unsigned_i = 1'b0;
    ls_wdata_i    = '0;
    repeat (3) @(posedge clk);
    #1 reset_i = 1'b0;
    test_fetch();
    test_store_load();
    test_mmio();
    test_errors();
    test_concurrent();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/axi_pkg.sv
hdl/lsu_pkg.sv
hdl/axil_if.sv
hdl/fetch_port.sv
hdl/ls_port.sv
hdl/axil_crossbar.sv
hdl/mem_bus_top.sv
tb/axil_slave_model.sv
tb/tb_mem_bus.sv

//--- run.sh
#!/bin/bash
# build and run the testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_mem_bus \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_mem_bus > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || grep -q "=== PASS ===" sim.log
